// File: verilog/kem_core_config.svh
`ifndef KEM_CORE_CONFIG_SVH
`define KEM_CORE_CONFIG_SVH

//////////////////////////////
// Memory geometry
//////////////////////////////

// Word and address widths of the shared memory
`define KEM_WORD_BITS 64
`define KEM_ADDR_BITS 10

//////////////////////////////
// Command port
//////////////////////////////

// One length field of the length word
`define KEM_LEN_BITS 16
`define KEM_OPCODE_BITS 5
// dst, src B, src A, opcode
`define KEM_CMD_BITS 35

// Session key size moved by cmov
`define KEM_KEY_WORDS 4

// Opcodes kept from the full core
`define KEM_OP_IDLE 5'd0
`define KEM_OP_COPY 5'd12
`define KEM_OP_VERIFY 5'd14
`define KEM_OP_CMOV 5'd15

`endif

// File: verilog/kem_core_pkg.sv
`include "kem_core_config.svh"

package kem_core_pkg;

	//////////////////////////////
	// Data path types
	//////////////////////////////

	// One memory word
	typedef logic [`KEM_WORD_BITS-1:0] word_t;

	// One memory address, also used for region bases
	typedef logic [`KEM_ADDR_BITS-1:0] addr_t;

	// Input or output length field of the length word
	typedef logic [`KEM_LEN_BITS-1:0] len_t;

	//////////////////////////////
	// Command decode
	//////////////////////////////

	// Opcodes this core still answers to
	// Every other value is dropped by the register block
	typedef enum logic [`KEM_OPCODE_BITS-1:0]
	{
		OP_IDLE = `KEM_OP_IDLE,
		// Block move, length in low bits of src B field
		OP_COPY = `KEM_OP_COPY,
		// Ciphertext compare, sets the fail flag
		OP_VERIFY = `KEM_OP_VERIFY,
		// Key select on the fail flag
		OP_CMOV = `KEM_OP_CMOV
	} opcode_e;

endpackage

// File: verilog/word_ram.sv
`timescale 1ns/1ps

`include "kem_core_config.svh"

module word_ram
(
	input logic clk,
	// External load and readback port
	input kem_core_pkg::addr_t address_ext,
	input kem_core_pkg::word_t dina_ext,
	input logic wea_ext,
	output kem_core_pkg::word_t doutb_ext,
	// Engine port
	input kem_core_pkg::addr_t eng_addr,
	input logic eng_we,
	input kem_core_pkg::word_t eng_wdata,
	output kem_core_pkg::word_t eng_rdata
);

	import kem_core_pkg::*;

	// 1024 x 64 storage, contents undefined after power up
	word_t mem [0:(1 << `KEM_ADDR_BITS)-1];

	// Both ports write on the same edge
	// Usage rule keeps them on different addresses
	always_ff @(posedge clk)
	begin
		if (wea_ext)
			mem[address_ext] <= dina_ext;
		if (eng_we)
			mem[eng_addr] <= eng_wdata;
	end

	// Registered reads, one cycle after the address
	always_ff @(posedge clk)
	begin
		doutb_ext <= mem[address_ext];
		eng_rdata <= mem[eng_addr];
	end

endmodule

// File: verilog/command_regs.sv
`timescale 1ns/1ps

`include "kem_core_config.svh"

module command_regs
(
	input logic clk,
	input logic rst_n,
	// Host side
	input logic [`KEM_CMD_BITS-1:0] command_in,
	input logic command_we0,
	input logic command_we1,
	// Engine status
	input logic busy,
	input logic finish,
	// Held command fields
	output kem_core_pkg::addr_t dst_addr,
	output kem_core_pkg::addr_t src_a_addr,
	output kem_core_pkg::addr_t src_b_addr,
	output kem_core_pkg::len_t in_len,
	// One cycle start pulses
	output logic start_copy,
	output logic start_verify,
	output logic start_cmov,
	// Done levels, held until idle command
	output logic done_copy,
	output logic done_verify,
	output logic done_cmov
);

	import kem_core_pkg::*;

	logic [`KEM_OPCODE_BITS-1:0] op_field;
	logic cmd_accept;
	logic op_runs;
	opcode_e active_op;

	//////////////////////////////
	// Command decode
	//////////////////////////////

	assign op_field = command_in[`KEM_OPCODE_BITS-1:0];

	// Start pulse still in flight counts as busy
	assign cmd_accept = command_we0 & ~busy & ~start_copy & ~start_verify & ~start_cmov;

	// Opcodes that launch the engine
	assign op_runs = (op_field == OP_COPY) || (op_field == OP_VERIFY) ||
		(op_field == OP_CMOV);

	// Fields from high to low: dst, src B, src A, opcode
	always_ff @(posedge clk)
	begin
		if (cmd_accept && op_runs)
		begin
			dst_addr <= command_in[34:25];
			src_b_addr <= command_in[24:15];
			src_a_addr <= command_in[14:5];
		end
		// Output length and spare bits belonged to hashing
		if (command_we1)
			in_len <= command_in[`KEM_LEN_BITS-1:0];
	end

	//////////////////////////////
	// Start and done control
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			start_copy <= 1'b0;
			start_verify <= 1'b0;
			start_cmov <= 1'b0;
			done_copy <= 1'b0;
			done_verify <= 1'b0;
			done_cmov <= 1'b0;
			active_op <= OP_IDLE;
		end
		else
		begin
			// Pulses last one cycle
			start_copy <= 1'b0;
			start_verify <= 1'b0;
			start_cmov <= 1'b0;
			// Raise the level of whatever was running
			if (finish)
			begin
				case (active_op)
					OP_COPY: done_copy <= 1'b1;
					OP_VERIFY: done_verify <= 1'b1;
					OP_CMOV: done_cmov <= 1'b1;
					default: ;
				endcase
			end
			if (cmd_accept)
			begin
				case (op_field)
					OP_IDLE:
					begin
						done_copy <= 1'b0;
						done_verify <= 1'b0;
						done_cmov <= 1'b0;
					end
					OP_COPY:
					begin
						start_copy <= 1'b1;
						active_op <= OP_COPY;
					end
					OP_VERIFY:
					begin
						start_verify <= 1'b1;
						active_op <= OP_VERIFY;
					end
					OP_CMOV:
					begin
						start_cmov <= 1'b1;
						active_op <= OP_CMOV;
					end
					// Unsupported opcode, nothing happens
					default: ;
				endcase
			end
		end
	end

endmodule

// File: verilog/mem_engine.sv
`timescale 1ns/1ps

`include "kem_core_config.svh"

module mem_engine
(
	input logic clk,
	input logic rst_n,
	// From the register block
	input logic start_copy,
	input logic start_verify,
	input logic start_cmov,
	input kem_core_pkg::addr_t dst_addr,
	input kem_core_pkg::addr_t src_a_addr,
	input kem_core_pkg::addr_t src_b_addr,
	input kem_core_pkg::len_t in_len,
	// Status back to the register block
	output logic busy,
	output logic finish,
	// Engine memory port
	output kem_core_pkg::addr_t eng_addr,
	output logic eng_we,
	output kem_core_pkg::word_t eng_wdata,
	input kem_core_pkg::word_t eng_rdata
);

	import kem_core_pkg::*;

	typedef enum logic [2:0]
	{
		S_IDLE,
		// Copy and cmov share the move loop
		S_MOVE_RD,
		S_MOVE_WR,
		// Verify reads A then B per word
		S_VER_A,
		S_VER_B,
		S_VER_LAST,
		S_DONE
	} state_t;

	state_t state;
	// Word counter and its limit
	len_t cnt;
	len_t len_q;
	logic last_word;
	addr_t offset;
	// Source base of the move loop
	addr_t src_q;
	// Destination address one cycle behind the read
	addr_t wr_addr_q;
	// Word from region A awaiting its partner
	word_t word_a;
	// Set by any mismatch in verify, read by cmov
	logic fail;

	assign offset = cnt[`KEM_ADDR_BITS-1:0];
	assign last_word = (cnt == len_q - 1'b1);

	assign busy = (state != S_IDLE);
	assign finish = (state == S_DONE);

	//////////////////////////////
	// Memory port
	//////////////////////////////

	always_comb
	begin
		eng_addr = src_a_addr + offset;
		eng_we = 1'b0;
		// Only the move loop writes, always with the word just read
		eng_wdata = eng_rdata;
		case (state)
			S_MOVE_RD: eng_addr = src_q + offset;
			S_MOVE_WR:
			begin
				eng_addr = wr_addr_q;
				eng_we = 1'b1;
			end
			S_VER_B: eng_addr = src_b_addr + offset;
			default: ;
		endcase
	end

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			cnt <= '0;
			fail <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					cnt <= '0;
					if (start_copy)
					begin
						// Length rides in the src B field
						state <= (src_b_addr == '0) ? S_DONE : S_MOVE_RD;
					end
					else if (start_verify)
					begin
						// Fresh compare, zero length stays clear
						fail <= 1'b0;
						state <= (in_len == '0) ? S_DONE : S_VER_A;
					end
					else if (start_cmov)
						state <= S_MOVE_RD;
				end
				S_MOVE_RD: state <= S_MOVE_WR;
				S_MOVE_WR:
				begin
					cnt <= cnt + 1'b1;
					state <= last_word ? S_DONE : S_MOVE_RD;
				end
				S_VER_A:
				begin
					// Data now on the port is B of the previous word
					if (cnt != '0)
						fail <= fail | (word_a != eng_rdata);
					state <= S_VER_B;
				end
				S_VER_B:
				begin
					cnt <= cnt + 1'b1;
					state <= last_word ? S_VER_LAST : S_VER_A;
				end
				// Last B word compared here
				S_VER_LAST:
				begin
					fail <= fail | (word_a != eng_rdata);
					state <= S_DONE;
				end
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Operation setup and data path, no reset needed
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE)
		begin
			if (start_copy)
			begin
				len_q <= len_t'(src_b_addr);
				src_q <= src_a_addr;
			end
			else if (start_verify)
				len_q <= in_len;
			else if (start_cmov)
			begin
				len_q <= len_t'(`KEM_KEY_WORDS);
				// Fallback string on failure, session key otherwise
				src_q <= fail ? src_a_addr : src_b_addr;
			end
		end
		if (state == S_MOVE_RD)
			wr_addr_q <= dst_addr + offset;
		// A word arrives while B is addressed
		if (state == S_VER_B)
			word_a <= eng_rdata;
	end

endmodule

// File: verilog/kem_core_top.sv
`timescale 1ns/1ps

`include "kem_core_config.svh"

module kem_core_top
(
	input logic clk,
	input logic rst_n,
	// External memory port
	input kem_core_pkg::addr_t address_ext,
	input kem_core_pkg::word_t dina_ext,
	input logic wea_ext,
	output kem_core_pkg::word_t doutb_ext,
	// Command port
	input logic [`KEM_CMD_BITS-1:0] command_in,
	input logic command_we0,
	input logic command_we1,
	// Per operation done levels
	output logic done_copy,
	output logic done_verify,
	output logic done_cmov
);

	import kem_core_pkg::*;

	//////////////////////////////
	// Internal nets
	//////////////////////////////

	// Held command fields
	addr_t dst_addr;
	addr_t src_a_addr;
	addr_t src_b_addr;
	len_t in_len;

	// Handoff between register block and engine
	logic start_copy;
	logic start_verify;
	logic start_cmov;
	logic busy;
	logic finish;

	// Engine side of the memory
	addr_t eng_addr;
	logic eng_we;
	word_t eng_wdata;
	word_t eng_rdata;

	//////////////////////////////
	// Instances
	//////////////////////////////

	// Command and length registers
	command_regs u_command_regs
	(
		.clk(clk),
		.rst_n(rst_n),
		.command_in(command_in),
		.command_we0(command_we0),
		.command_we1(command_we1),
		.busy(busy),
		.finish(finish),
		.dst_addr(dst_addr),
		.src_a_addr(src_a_addr),
		.src_b_addr(src_b_addr),
		.in_len(in_len),
		.start_copy(start_copy),
		.start_verify(start_verify),
		.start_cmov(start_cmov),
		.done_copy(done_copy),
		.done_verify(done_verify),
		.done_cmov(done_cmov)
	);

	// Copy, verify and cmov sequencer
	mem_engine u_mem_engine
	(
		.clk(clk),
		.rst_n(rst_n),
		.start_copy(start_copy),
		.start_verify(start_verify),
		.start_cmov(start_cmov),
		.dst_addr(dst_addr),
		.src_a_addr(src_a_addr),
		.src_b_addr(src_b_addr),
		.in_len(in_len),
		.busy(busy),
		.finish(finish),
		.eng_addr(eng_addr),
		.eng_we(eng_we),
		.eng_wdata(eng_wdata),
		.eng_rdata(eng_rdata)
	);

	// Shared 1024 word memory
	word_ram u_word_ram
	(
		.clk(clk),
		.address_ext(address_ext),
		.dina_ext(dina_ext),
		.wea_ext(wea_ext),
		.doutb_ext(doutb_ext),
		.eng_addr(eng_addr),
		.eng_we(eng_we),
		.eng_wdata(eng_wdata),
		.eng_rdata(eng_rdata)
	);

endmodule

// File: testbench/tb_kem_core.sv
`timescale 1ns/1ps

`include "kem_core_config.svh"

module tb_kem_core;

	import kem_core_pkg::*;

	// Estimated load, read and operation cycles with margin
	localparam int CYCLE_LIMIT = 20000;
	localparam int DONE_WAIT = 2000;
	localparam int MEM_WORDS = 1 << `KEM_ADDR_BITS;

	logic clk;
	logic rst_n;
	addr_t address_ext;
	word_t dina_ext;
	logic wea_ext;
	word_t doutb_ext;
	logic [`KEM_CMD_BITS-1:0] command_in;
	logic command_we0;
	logic command_we1;
	logic done_copy;
	logic done_verify;
	logic done_cmov;

	// High for the one cycle that carries an accepted idle command
	logic idle_sent;

	// Reference memory and fail flag
	word_t model [0:MEM_WORDS-1];
	logic model_fail;

	int checks;
	int errors;
	int tests_run;
	int tests_failed;
	int test_errors;
	int cycles;
	string test_name;

	kem_core_top DUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.address_ext(address_ext),
		.dina_ext(dina_ext),
		.wea_ext(wea_ext),
		.doutb_ext(doutb_ext),
		.command_in(command_in),
		.command_we0(command_we0),
		.command_we1(command_we1),
		.done_copy(done_copy),
		.done_verify(done_verify),
		.done_cmov(done_cmov)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	//////////////////////////////
	// Done level properties
	//////////////////////////////

	// Reset clears every done level
	assert property (@(posedge clk) !rst_n |=> (!done_copy && !done_verify && !done_cmov))
	else
	begin
		errors++;
		$display("ERR time %0t done levels after reset: expected 000, got %b%b%b",
			$time, done_copy, done_verify, done_cmov);
	end

	// Idle command drops them one cycle later
	assert property (@(posedge clk) disable iff (!rst_n)
		idle_sent |=> (!done_copy && !done_verify && !done_cmov))
	else
	begin
		errors++;
		$display("ERR time %0t done levels after idle: expected 000, got %b%b%b",
			$time, done_copy, done_verify, done_cmov);
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic done_level(input int which);
		case (which)
			0: return done_copy;
			1: return done_verify;
			default: return done_cmov;
		endcase
	endfunction

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("ERR time %0t %s: expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_errors)
			$display("Test %0d %s: ok", tests_run, test_name);
		else
		begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, test_name,
				errors - test_errors);
		end
	endtask

	// One external write, model follows
	task automatic write_word(input addr_t a, input word_t d);
		@(negedge clk);
		address_ext = a;
		dina_ext = d;
		wea_ext = 1'b1;
		model[a] = d;
		@(negedge clk);
		wea_ext = 1'b0;
	endtask

	// Data is due one cycle after the address is sampled
	task automatic check_word(input addr_t a);
		word_t expected;
		@(negedge clk);
		address_ext = a;
		wea_ext = 1'b0;
		expected = model[a];
		@(negedge clk);
		checks++;
		assert (doutb_ext === expected)
		else
		begin
			errors++;
			$display("ERR time %0t doutb_ext at %0d: expected %h, got %h",
				$time, a, expected, doutb_ext);
		end
	endtask

	task automatic check_region(input addr_t base, input int n);
		for (int i = 0; i < n; i++)
			check_word(base + addr_t'(i));
	endtask

	task automatic fill_random(input addr_t base, input int n);
		for (int i = 0; i < n; i++)
			write_word(base + addr_t'(i), {$urandom(), $urandom()});
	endtask

	// Command word, high to low: dst, src B, src A, opcode
	task automatic send_command(input logic [4:0] op, input addr_t dst, input addr_t src_b,
		input addr_t src_a);
		@(negedge clk);
		command_in = {dst, src_b, src_a, op};
		command_we0 = 1'b1;
		@(negedge clk);
		command_we0 = 1'b0;
	endtask

	// Spare bits, output length, input length
	task automatic write_length(input len_t n);
		@(negedge clk);
		command_in = {3'b000, 16'd0, n};
		command_we1 = 1'b1;
		@(negedge clk);
		command_we1 = 1'b0;
	endtask

	// Only sent while the engine is idle
	task automatic clear_done();
		@(negedge clk);
		command_in = '0;
		command_we0 = 1'b1;
		idle_sent = 1'b1;
		@(negedge clk);
		command_we0 = 1'b0;
		idle_sent = 1'b0;
		check_bit("done_copy", 1'b0, done_copy);
		check_bit("done_verify", 1'b0, done_verify);
		check_bit("done_cmov", 1'b0, done_cmov);
	endtask

	task automatic wait_done(input int which, input string name);
		int waited;
		waited = 0;
		while (!done_level(which) && waited < DONE_WAIT)
		begin
			@(negedge clk);
			waited++;
		end
		checks++;
		assert (done_level(which))
		else
		begin
			errors++;
			$display("%s never rose within %0d cycles of the command", name, DONE_WAIT);
		end
	endtask

	//////////////////////////////
	// Operations and their model
	//////////////////////////////

	// Length goes in the src B field
	task automatic run_copy(input addr_t src, input addr_t dst, input int n);
		send_command(`KEM_OP_COPY, dst, addr_t'(n), src);
		wait_done(0, "done_copy");
		for (int i = 0; i < n; i++)
			model[dst + addr_t'(i)] = model[src + addr_t'(i)];
	endtask

	// Any differing word sets the flag, zero length leaves it clear
	task automatic run_verify(input addr_t a, input addr_t b, input int n);
		write_length(len_t'(n));
		send_command(`KEM_OP_VERIFY, '0, b, a);
		wait_done(1, "done_verify");
		model_fail = 1'b0;
		for (int i = 0; i < n; i++)
			if (model[a + addr_t'(i)] !== model[b + addr_t'(i)])
				model_fail = 1'b1;
	endtask

	// Fallback from A on failure, key from B otherwise
	task automatic run_cmov(input addr_t a, input addr_t b, input addr_t dst);
		send_command(`KEM_OP_CMOV, dst, b, a);
		wait_done(2, "done_cmov");
		for (int i = 0; i < `KEM_KEY_WORDS; i++)
			model[dst + addr_t'(i)] = model_fail ? model[a + addr_t'(i)] : model[b + addr_t'(i)];
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int n;
		int pos;
		addr_t hit;
		void'($urandom(75825));
		rst_n = 1'b0;
		address_ext = '0;
		dina_ext = '0;
		wea_ext = 1'b0;
		command_in = '0;
		command_we0 = 1'b0;
		command_we1 = 1'b0;
		idle_sent = 1'b0;
		model_fail = 1'b0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_test("reset and external port");
		check_bit("done_copy", 1'b0, done_copy);
		check_bit("done_verify", 1'b0, done_verify);
		check_bit("done_cmov", 1'b0, done_cmov);
		fill_random(10'd0, 64);
		check_region(10'd0, 64);
		end_test();

		start_test("copy");
		n = 1 + int'($urandom() % 40);
		run_copy(10'd0, 10'd800, n);
		check_region(10'd800, n);
		// Level holds through the readback
		check_bit("done_copy", 1'b1, done_copy);
		clear_done();
		end_test();

		// Regions A and B, fallback string and session key
		start_test("verify equal then cmov");
		for (int i = 0; i < 136; i++)
		begin
			dina_ext = {$urandom(), $urandom()};
			write_word(10'd100 + addr_t'(i), dina_ext);
			write_word(10'd300 + addr_t'(i), dina_ext);
		end
		fill_random(10'd700, `KEM_KEY_WORDS);
		fill_random(10'd720, `KEM_KEY_WORDS);
		fill_random(10'd600, `KEM_KEY_WORDS);
		run_verify(10'd100, 10'd300, 136);
		run_cmov(10'd700, 10'd720, 10'd600);
		check_region(10'd600, `KEM_KEY_WORDS);
		clear_done();
		end_test();

		start_test("verify altered then cmov");
		pos = int'($urandom() % 136);
		hit = 10'd100 + addr_t'(pos);
		// Nonzero flip mask so the word always differs
		write_word(hit, model[hit] ^ {32'h0, $urandom() | 32'h1});
		fill_random(10'd600, `KEM_KEY_WORDS);
		run_verify(10'd100, 10'd300, 136);
		run_cmov(10'd700, 10'd720, 10'd600);
		check_region(10'd600, `KEM_KEY_WORDS);
		clear_done();
		end_test();

		start_test("busy command and bad opcode");
		fill_random(10'd950, `KEM_KEY_WORDS);
		// Two commands land while the copy runs
		send_command(`KEM_OP_COPY, 10'd860, 10'd40, 10'd0);
		send_command(`KEM_OP_VERIFY, 10'd0, 10'd300, 10'd100);
		send_command(`KEM_OP_CMOV, 10'd950, 10'd720, 10'd700);
		wait_done(0, "done_copy");
		for (int i = 0; i < 40; i++)
			model[10'd860 + addr_t'(i)] = model[addr_t'(i)];
		repeat (10) @(negedge clk);
		check_bit("done_verify", 1'b0, done_verify);
		check_bit("done_cmov", 1'b0, done_cmov);
		check_region(10'd860, 40);
		check_region(10'd950, `KEM_KEY_WORDS);
		clear_done();
		// Opcode 7 is not decoded
		send_command(5'd7, 10'd950, 10'd4, 10'd700);
		repeat (20) @(negedge clk);
		check_bit("done_copy", 1'b0, done_copy);
		check_bit("done_verify", 1'b0, done_verify);
		check_bit("done_cmov", 1'b0, done_cmov);
		check_region(10'd950, `KEM_KEY_WORDS);
		end_test();

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: build.f
+incdir+verilog
verilog/kem_core_pkg.sv
verilog/word_ram.sv
verilog/command_regs.sv
verilog/mem_engine.sv
verilog/kem_core_top.sv
testbench/tb_kem_core.sv

// File: Makefile
SIM := obj_dir/Vtb_kem_core

SRCS := verilog/kem_core_config.svh \
	verilog/kem_core_pkg.sv \
	verilog/word_ram.sv \
	verilog/command_regs.sv \
	verilog/mem_engine.sv \
	verilog/kem_core_top.sv \
	testbench/tb_kem_core.sv

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_kem_core \
		-Mdir obj_dir -o Vtb_kem_core -f build.f

clean:
	rm -rf obj_dir
